// ==== source/vec_pkg.sv ====
// Vector unit package with widths, operation codes and instruction formats
package vec_pkg;

  // Element and register file geometry
  localparam int unsigned ElenBits    = 32;
  localparam int unsigned NrVRegs     = 8;
  localparam int unsigned VRegIdxBits = 3;
  localparam int unsigned InsnBits    = 32;
  localparam int unsigned ElemIdxBits = 8;

  typedef logic [ElenBits-1:0]    elen_t;
  typedef logic [VRegIdxBits-1:0] vreg_idx_t;

  typedef enum logic [3:0] {
    VADD     = 4'd0,
    VSUB     = 4'd1,
    VAND     = 4'd2,
    VOR      = 4'd3,
    VXOR     = 4'd4,
    VBCAST   = 4'd5,
    VEXTRACT = 4'd6,
    VREDSUM  = 4'd7
  } vec_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////////////////////

  // Arithmetic format, also used by VBCAST
  typedef struct packed {
    vec_op_e     op;
    vreg_idx_t   vd;
    vreg_idx_t   vs1;
    vreg_idx_t   vs2;
    logic        use_scalar;
    logic [17:0] reserved;
  } vec_arith_t;

  // Element-move format for VEXTRACT and VREDSUM
  typedef struct packed {
    vec_op_e                op;
    vreg_idx_t              vd;
    logic [2:0]             unused;
    vreg_idx_t              vs2;
    logic [ElemIdxBits-1:0] elem_idx;
    logic [10:0]            reserved;
  } vec_move_t;

  // Op and vs2 sit at the same bits in both views
  typedef union packed {
    vec_arith_t arith;
    vec_move_t  move;
  } vec_insn_u;

  // Decoded request handed from dispatcher to sequencer
  typedef struct packed {
    vec_op_e                op;
    vreg_idx_t              vd;
    vreg_idx_t              vs1;
    vreg_idx_t              vs2;
    logic                   use_scalar;
    logic [ElemIdxBits-1:0] elem_idx;
    elen_t                  scalar;
  } vec_req_t;

endpackage

// ==== source/vec_issue_if.sv ====
// Issue bus carrying the running instruction from the sequencer to lanes and scalar unit
`timescale 1ns/1ps

interface vec_issue_if;

  // One-cycle pulse, the fields below hold until the instruction ends
  logic                               start;
  vec_pkg::vec_op_e                   op;
  vec_pkg::vreg_idx_t                 vd;
  vec_pkg::vreg_idx_t                 vs1;
  vec_pkg::vreg_idx_t                 vs2;
  logic                               use_scalar;
  vec_pkg::elen_t                     scalar_op;
  logic [vec_pkg::ElemIdxBits-1:0]    elem_idx;

  modport seq (
    output start, op, vd, vs1, vs2, use_scalar, scalar_op, elem_idx
  );

  modport lane (
    input start, op, vd, vs1, vs2, use_scalar, scalar_op, elem_idx
  );

  modport scalar (
    input op, elem_idx
  );

endinterface

// ==== source/vec_dispatcher.sv ====
// Vector dispatcher that decodes core instructions and holds one pending request
`timescale 1ns/1ps

module vec_dispatcher (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Core side
  input  logic                             insn_valid_i,
  input  logic [vec_pkg::InsnBits-1:0]     insn_i,
  input  vec_pkg::elen_t                   scalar_i,
  output logic                             insn_ready_o,
  // Sequencer side
  output vec_pkg::vec_req_t                req_o,
  output logic                             req_valid_o,
  input  logic                             req_ready_i,
  output logic                             empty_o
);

  vec_pkg::vec_insn_u insn;
  vec_pkg::vec_req_t  req_d;
  vec_pkg::vec_req_t  req_q;
  logic               full_q;
  logic               accept;
  logic               is_move;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign insn = insn_i;

  // Scalar-returning ops use the element-move format
  assign is_move = (insn.move.op == vec_pkg::VEXTRACT) ||
                   (insn.move.op == vec_pkg::VREDSUM);

  always_comb begin
    req_d            = '0;
    req_d.op         = insn.arith.op;
    req_d.vd         = insn.arith.vd;
    req_d.vs2        = insn.arith.vs2;
    req_d.scalar     = scalar_i;
    if (is_move) begin
      req_d.elem_idx = insn.move.elem_idx;
    end else begin
      req_d.vs1        = insn.arith.vs1;
      req_d.use_scalar = insn.arith.use_scalar;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Hold slot
  ////////////////////////////////////////////////////////////////////////////

  // Free slot, or the held one leaves this cycle
  assign insn_ready_o = !full_q || req_ready_i;
  assign accept       = insn_valid_i && insn_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_d;
    end
  end

  assign req_valid_o = full_q;
  assign req_o       = req_q;
  assign empty_o     = !full_q;

endmodule

// ==== source/vec_sequencer.sv ====
// Vector sequencer that runs one instruction at a time across lanes and scalar unit
`timescale 1ns/1ps

module vec_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Dispatcher side
  input  vec_pkg::vec_req_t    req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Broadcast to lanes and scalar unit
  vec_issue_if.seq             issue,
  input  logic [NrLanes-1:0]   lane_done_i,
  input  logic                 scalar_valid_i,
  input  vec_pkg::elen_t       scalar_result_i,
  // Response to the core
  output logic                 resp_valid_o,
  output vec_pkg::elen_t       resp_o,
  output logic                 busy_o
);

  typedef enum logic {
    SeqIdle,
    SeqRun
  } seq_state_e;

  seq_state_e         state_q;
  logic [NrLanes-1:0] done_q;
  logic               take;
  logic               ret_scalar;
  logic               all_done;
  logic               finish;

  assign req_ready_o = (state_q == SeqIdle);
  assign take        = req_valid_i && req_ready_o;
  assign busy_o      = (state_q == SeqRun);

  // Ops ending on the scalar result instead of lane completion
  assign ret_scalar = (issue.op == vec_pkg::VEXTRACT) || (issue.op == vec_pkg::VREDSUM);
  assign all_done   = &(done_q | lane_done_i);
  assign finish     = busy_o && (ret_scalar ? scalar_valid_i : all_done);

  assign resp_valid_o = busy_o && ret_scalar && scalar_valid_i;
  assign resp_o       = scalar_result_i;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= SeqIdle;
      issue.start <= 1'b0;
      done_q      <= '0;
    end else begin
      // Start follows the accepting cycle
      issue.start <= take;
      case (state_q)
        SeqIdle: begin
          if (take) begin
            state_q <= SeqRun;
          end
        end
        SeqRun: begin
          done_q <= done_q | lane_done_i;
          if (finish) begin
            state_q <= SeqIdle;
            done_q  <= '0;
          end
        end
        default: state_q <= SeqIdle;
      endcase
    end
  end

  // Instruction fields stay put for the whole run
  always_ff @(posedge clk_i) begin
    if (take) begin
      issue.op         <= req_i.op;
      issue.vd         <= req_i.vd;
      issue.vs1        <= req_i.vs1;
      issue.vs2        <= req_i.vs2;
      issue.use_scalar <= req_i.use_scalar;
      issue.scalar_op  <= req_i.scalar;
      issue.elem_idx   <= req_i.elem_idx;
    end
  end

endmodule

// ==== source/vec_lane.sv ====
// Vector lane holding its register-file slice and an integer ALU
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  vec_issue_if.lane      issue,
  // Streamed vs2 element for the scalar unit
  output vec_pkg::elen_t elem_o,
  output logic           elem_valid_o,
  output logic           done_o
);

  localparam int unsigned ElemsPerVec  = VLEN / vec_pkg::ElenBits;
  localparam int unsigned ElemsPerLane = ElemsPerVec / NrLanes;
  localparam int unsigned StepBits     = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;

  // Local slot s holds global element s*NrLanes + lane
  vec_pkg::elen_t      vrf_q [vec_pkg::NrVRegs][ElemsPerLane];

  logic                active_q;
  logic [StepBits-1:0] step_q;
  logic                last_step;
  vec_pkg::elen_t      vs1_elem;
  vec_pkg::elen_t      vs2_elem;
  vec_pkg::elen_t      op_b;
  vec_pkg::elen_t      alu_res;
  logic                writes_vd;

  ////////////////////////////////////////////////////////////////////////////
  // Step counter
  ////////////////////////////////////////////////////////////////////////////

  assign last_step = (step_q == StepBits'(ElemsPerLane - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      step_q   <= '0;
    end else if (issue.start) begin
      active_q <= 1'b1;
      step_q   <= '0;
    end else if (active_q) begin
      if (last_step) begin
        active_q <= 1'b0;
        step_q   <= '0;
      end else begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand read and ALU
  ////////////////////////////////////////////////////////////////////////////

  assign vs1_elem = vrf_q[issue.vs1][step_q];
  assign vs2_elem = vrf_q[issue.vs2][step_q];
  assign op_b     = issue.use_scalar ? issue.scalar_op : vs1_elem;

  // Result is vs2 op b, with wrapping arithmetic
  always_comb begin
    writes_vd = 1'b1;
    case (issue.op)
      vec_pkg::VADD:   alu_res = vs2_elem + op_b;
      vec_pkg::VSUB:   alu_res = vs2_elem - op_b;
      vec_pkg::VAND:   alu_res = vs2_elem & op_b;
      vec_pkg::VOR:    alu_res = vs2_elem | op_b;
      vec_pkg::VXOR:   alu_res = vs2_elem ^ op_b;
      vec_pkg::VBCAST: alu_res = issue.scalar_op;
      default: begin
        // Scalar-returning ops only stream vs2
        alu_res   = vs2_elem;
        writes_vd = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (active_q && writes_vd) begin
      vrf_q[issue.vd][step_q] <= alu_res;
    end
  end

  // Every step streams its vs2 element
  assign elem_o       = vs2_elem;
  assign elem_valid_o = active_q;
  assign done_o       = active_q && last_step;

endmodule

// ==== source/vec_scalar_unit.sv ====
// Scalar result unit for sum reduction and element extraction
`timescale 1ns/1ps

module vec_scalar_unit #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  vec_issue_if.scalar                   issue,
  input  vec_pkg::elen_t [NrLanes-1:0]  elem_i,
  input  logic [NrLanes-1:0]            elem_valid_i,
  output vec_pkg::elen_t                result_o,
  output logic                          result_valid_o
);

  localparam int unsigned ElemsPerVec  = VLEN / vec_pkg::ElenBits;
  localparam int unsigned ElemsPerLane = ElemsPerVec / NrLanes;
  localparam int unsigned StepBits     = (ElemsPerLane > 1) ? $clog2(ElemsPerLane) : 1;
  localparam int unsigned LaneBits     = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  logic [StepBits-1:0]             step_q;
  logic                            step_valid;
  logic                            last_step;
  logic                            is_redsum;
  logic                            is_extract;
  logic [vec_pkg::ElemIdxBits-1:0] gidx;
  logic [LaneBits-1:0]             lane_sel;
  logic [StepBits-1:0]             slot_sel;
  vec_pkg::elen_t                  lane_sum;
  vec_pkg::elen_t                  result_q;
  logic                            result_valid_q;

  // Lanes step in lockstep
  assign step_valid = |elem_valid_i;
  assign last_step  = (step_q == StepBits'(ElemsPerLane - 1));
  assign is_redsum  = (issue.op == vec_pkg::VREDSUM);
  assign is_extract = (issue.op == vec_pkg::VEXTRACT);

  // Out-of-range indices wrap around the vector
  assign gidx     = vec_pkg::ElemIdxBits'(issue.elem_idx % ElemsPerVec);
  assign lane_sel = LaneBits'(gidx % NrLanes);
  assign slot_sel = StepBits'(gidx / NrLanes);

  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      lane_sum = lane_sum + elem_i[l];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      step_q         <= '0;
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= step_valid && last_step && (is_redsum || is_extract);
      if (step_valid) begin
        step_q <= last_step ? '0 : step_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_valid) begin
      if (is_redsum) begin
        result_q <= ((step_q == '0) ? '0 : result_q) + lane_sum;
      end else if (is_extract && (step_q == slot_sel)) begin
        result_q <= elem_i[lane_sel];
      end
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

endmodule

// ==== source/vec_core.sv ====
// Vector execution unit top level joining dispatcher, sequencer, lanes and scalar unit
`timescale 1ns/1ps

module vec_core #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Instruction port
  input  logic                         insn_valid_i,
  input  logic [vec_pkg::InsnBits-1:0] insn_i,
  input  vec_pkg::elen_t               scalar_i,
  output logic                         insn_ready_o,
  // Scalar response
  output logic                         resp_valid_o,
  output vec_pkg::elen_t               resp_o,
  output logic                         idle_o
);

  vec_pkg::vec_req_t             req;
  logic                          req_valid;
  logic                          req_ready;
  logic                          disp_empty;
  logic                          seq_busy;
  logic [NrLanes-1:0]            lane_done;
  logic [NrLanes-1:0]            lane_elem_valid;
  vec_pkg::elen_t [NrLanes-1:0]  lane_elem;
  vec_pkg::elen_t                scalar_result;
  logic                          scalar_valid;

  vec_issue_if issue ();

  ////////////////////////////////////////////////////////////////////////////
  // Front end
  ////////////////////////////////////////////////////////////////////////////

  vec_dispatcher u_dispatcher (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i      ),
    .scalar_i     (scalar_i    ),
    .insn_ready_o (insn_ready_o),
    .req_o        (req         ),
    .req_valid_o  (req_valid   ),
    .req_ready_i  (req_ready   ),
    .empty_o      (disp_empty  )
  );

  vec_sequencer #(
    .NrLanes (NrLanes)
  ) u_sequencer (
    .clk_i           (clk_i        ),
    .rst_n_i         (rst_n_i      ),
    .req_i           (req          ),
    .req_valid_i     (req_valid    ),
    .req_ready_o     (req_ready    ),
    .issue           (issue.seq    ),
    .lane_done_i     (lane_done    ),
    .scalar_valid_i  (scalar_valid ),
    .scalar_result_i (scalar_result),
    .resp_valid_o    (resp_valid_o ),
    .resp_o          (resp_o       ),
    .busy_o          (seq_busy     )
  );

  assign idle_o = disp_empty && !seq_busy;

  ////////////////////////////////////////////////////////////////////////////
  // Back end
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .NrLanes (NrLanes),
      .VLEN    (VLEN   )
    ) u_lane (
      .clk_i        (clk_i             ),
      .rst_n_i      (rst_n_i           ),
      .issue        (issue.lane        ),
      .elem_o       (lane_elem[l]      ),
      .elem_valid_o (lane_elem_valid[l]),
      .done_o       (lane_done[l]      )
    );
  end

  vec_scalar_unit #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) u_scalar_unit (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .issue          (issue.scalar   ),
    .elem_i         (lane_elem      ),
    .elem_valid_i   (lane_elem_valid),
    .result_o       (scalar_result  ),
    .result_valid_o (scalar_valid   )
  );

endmodule

// ==== verification/vec_ref_model.svh ====
// Vector unit reference model with a global-index register file and a random source
`ifndef VEC_REF_MODEL_SVH
`define VEC_REF_MODEL_SVH

// Model register file, indexed by global element number
vec_pkg::elen_t model_vrf [vec_pkg::NrVRegs][ElemsPerVec];
logic [31:0]    lcg_state = 32'hea31_06f8;

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Low LCG bits repeat quickly, so small picks use the upper bits
function automatic int unsigned rand_below(input int unsigned n);
  logic [31:0] r;
  r = next_rand();
  return {8'd0, r[31:8]} % n;
endfunction

////////////////////////////////////////////////////////////////////////////
// Instruction effect
////////////////////////////////////////////////////////////////////////////

// Updates the model and returns the scalar the op should produce
function automatic vec_pkg::elen_t ref_exec(input vec_pkg::vec_op_e   op,
                                            input vec_pkg::vreg_idx_t vd,
                                            input vec_pkg::vreg_idx_t vs1,
                                            input vec_pkg::vreg_idx_t vs2,
                                            input logic               use_scalar,
                                            input logic [7:0]         idx,
                                            input vec_pkg::elen_t     scalar);
  vec_pkg::elen_t b;
  vec_pkg::elen_t res;
  res = '0;
  for (int unsigned i = 0; i < ElemsPerVec; i++) begin
    b = use_scalar ? scalar : model_vrf[vs1][i];
    case (op)
      vec_pkg::VADD:    model_vrf[vd][i] = model_vrf[vs2][i] + b;
      vec_pkg::VSUB:    model_vrf[vd][i] = model_vrf[vs2][i] - b;
      vec_pkg::VAND:    model_vrf[vd][i] = model_vrf[vs2][i] & b;
      vec_pkg::VOR:     model_vrf[vd][i] = model_vrf[vs2][i] | b;
      vec_pkg::VXOR:    model_vrf[vd][i] = model_vrf[vs2][i] ^ b;
      vec_pkg::VBCAST:  model_vrf[vd][i] = scalar;
      vec_pkg::VREDSUM: res = res + model_vrf[vs2][i];
      vec_pkg::VEXTRACT: begin
        // Index wraps around the vector length
        if (i == ({24'd0, idx} % ElemsPerVec)) begin
          res = model_vrf[vs2][i];
        end
      end
      default: res = res;
    endcase
  end
  return res;
endfunction

`endif

// ==== verification/tb_vec_core.sv ====
// Testbench for the vector execution unit, checking scalar responses against a reference model
`timescale 1ns/1ps

module tb_vec_core;

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned VLEN          = 256;
  localparam int unsigned ElemsPerVec   = VLEN / vec_pkg::ElenBits;
  localparam int unsigned TimeoutCycles = 200;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         insn_valid_i;
  logic [vec_pkg::InsnBits-1:0] insn_i;
  vec_pkg::elen_t               scalar_i;
  logic                         insn_ready_o;
  logic                         resp_valid_o;
  vec_pkg::elen_t               resp_o;
  logic                         idle_o;

  // Expected scalar results in issue order
  vec_pkg::elen_t exp_q [$];
  int unsigned    check_count;
  int unsigned    error_count;
  int unsigned    resp_count;
  int unsigned    exp_total;
  int unsigned    stall_cycles;
  logic           aborted;

  `include "vec_ref_model.svh"

  vec_core #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) u_vec_core (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i      ),
    .scalar_i     (scalar_i    ),
    .insn_ready_o (insn_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o      ),
    .idle_o       (idle_o      )
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  function automatic vec_pkg::vreg_idx_t rand_reg();
    return vec_pkg::vreg_idx_t'(rand_below(vec_pkg::NrVRegs));
  endfunction

  // Move format for scalar-returning ops, arithmetic format otherwise
  function automatic logic [31:0] encode_insn(input vec_pkg::vec_op_e op,
                                              input vec_pkg::vreg_idx_t vd,
                                              input vec_pkg::vreg_idx_t vs1,
                                              input vec_pkg::vreg_idx_t vs2,
                                              input logic use_scalar,
                                              input logic [7:0] idx,
                                              input logic [31:0] junk);
    if ((op == vec_pkg::VEXTRACT) || (op == vec_pkg::VREDSUM)) begin
      return {op, vd, junk[2:0], vs2, idx, junk[13:3]};
    end else begin
      return {op, vd, vs1, vs2, use_scalar, junk[31:14]};
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, called on a falling edge, leaves insn_valid_i high
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_insn(input vec_pkg::vec_op_e op, input vec_pkg::vreg_idx_t vd,
                          input vec_pkg::vreg_idx_t vs1, input vec_pkg::vreg_idx_t vs2,
                          input logic use_scalar, input logic [7:0] idx,
                          input vec_pkg::elen_t scalar);
    vec_pkg::elen_t expected;
    logic           has_resp;
    logic [31:0]    word;
    int unsigned    waited;
    has_resp = (op == vec_pkg::VEXTRACT) || (op == vec_pkg::VREDSUM);
    word     = encode_insn(op, vd, vs1, vs2, use_scalar, idx, next_rand());
    expected = ref_exec(op, vd, vs1, vs2, use_scalar, idx, scalar);
    if (!aborted) begin
      insn_valid_i = 1'b1;
      insn_i       = word;
      scalar_i     = scalar;
      waited       = 0;
      while (!insn_ready_o && (waited < TimeoutCycles)) begin
        stall_cycles++;
        waited++;
        @(negedge clk_i);
      end
      if (!insn_ready_o) begin
        error_count++;
        aborted = 1'b1;
        $display("Timeout at %0t: the unit never accepted instruction 0x%08h", $time, word);
      end else begin
        if (has_resp) begin
          exp_q.push_back(expected);
          exp_total++;
        end
        @(negedge clk_i);
        // The held instruction keeps the unit busy
        compare_value("idle_o", 32'(idle_o), 32'd0);
      end
    end
  endtask

  task automatic wait_idle();
    int unsigned waited;
    insn_valid_i = 1'b0;
    waited       = 0;
    if (!aborted) begin
      while (!(idle_o && (exp_q.size() == 0)) && (waited < TimeoutCycles)) begin
        waited++;
        @(negedge clk_i);
      end
      if (!(idle_o && (exp_q.size() == 0))) begin
        error_count++;
        aborted = 1'b1;
        $display("Timeout at %0t: the unit did not drain, %0d responses still missing",
                 $time, exp_q.size());
      end
    end
  endtask

  // Response monitor
  always @(posedge clk_i) begin
    if (rst_n_i && resp_valid_o) begin
      resp_count++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Error at %0t: a response arrived with no instruction waiting for one", $time);
      end else begin
        compare_value("resp_o", resp_o, exp_q.pop_front());
      end
    end
  end

  initial begin
    vec_pkg::vreg_idx_t vreg;
    rst_n_i      = 1'b0;
    insn_valid_i = 1'b0;
    insn_i       = '0;
    scalar_i     = '0;
    check_count  = 0;
    error_count  = 0;
    resp_count   = 0;
    exp_total    = 0;
    stall_cycles = 0;
    aborted      = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    compare_value("insn_ready_o", 32'(insn_ready_o), 32'd1);
    compare_value("idle_o", 32'(idle_o), 32'd1);
    compare_value("resp_valid_o", 32'(resp_valid_o), 32'd0);

    // Broadcast fills every register, then read each element back
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      run_insn(vec_pkg::VBCAST, vec_pkg::vreg_idx_t'(r), '0, '0, 1'b1, '0, next_rand());
    end
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      for (int e = 0; e < ElemsPerVec; e++) begin
        run_insn(vec_pkg::VEXTRACT, '0, '0, vec_pkg::vreg_idx_t'(r), 1'b0, 8'(e), next_rand());
      end
    end
    wait_idle();

    // Random arithmetic, each result read back in full
    repeat (40) begin
      vreg = rand_reg();
      run_insn(vec_pkg::vec_op_e'(4'(rand_below(5))), vreg, rand_reg(), rand_reg(),
               1'(rand_below(2)), '0, next_rand());
      for (int e = 0; e < ElemsPerVec; e++) begin
        run_insn(vec_pkg::VEXTRACT, '0, '0, vreg, 1'b0, 8'(e), next_rand());
      end
    end
    wait_idle();

    repeat (16) begin
      run_insn(vec_pkg::VREDSUM, '0, '0, rand_reg(), 1'b0, 8'(rand_below(256)), next_rand());
    end
    // Out-of-range extract indices
    repeat (16) begin
      run_insn(vec_pkg::VEXTRACT, '0, '0, rand_reg(), 1'b0,
               8'(ElemsPerVec + rand_below(256 - ElemsPerVec)), next_rand());
    end
    wait_idle();

    // Mixed burst with insn_valid_i held high throughout
    stall_cycles = 0;
    repeat (24) begin
      run_insn(vec_pkg::vec_op_e'(4'(rand_below(8))), rand_reg(), rand_reg(), rand_reg(),
               1'(rand_below(2)), 8'(rand_below(256)), next_rand());
    end
    wait_idle();
    check_count++;
    if (stall_cycles == 0) begin
      error_count++;
      $display("Error: insn_ready_o never went low during the back-to-back burst");
    end

    repeat (2) @(negedge clk_i);
    compare_value("response count", resp_count, exp_total);
    $display("Summary: %0d checks, %0d errors, %0d of %0d responses received",
             check_count, error_count, resp_count, exp_total);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verification
source/vec_pkg.sv
source/vec_issue_if.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_scalar_unit.sv
source/vec_core.sv
verification/tb_vec_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the vector unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing --top-module tb_vec_core -f project.f -o sim_vec_core &&
./obj_dir/sim_vec_core > sim.log

cat sim.log 2>/dev/null

grep -q "All checks passed" sim.log && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
